// ==== compile.f ====
common/pinmux_pkg.sv
hdl/reg_decode.sv
glbl/glbl_reg.sv
gpio/gpio_edge.sv
gpio/gpio_regs.sv
pinmux/pad_mux.sv
hdl/pinmux_top.sv
bench/pinmux_chk.sv
bench/tb_pinmux_top.sv

// ==== bench/tb_pinmux_top.sv ====
// ---------------------------------------------------------------------
// Testbench for the pin-multiplexing peripheral
// Table of register accesses with pad and interrupt expectations
// applied in order through a bus task that waits for ack
// ---------------------------------------------------------------------
module tb_pinmux_top import pinmux_pkg::*; ();

   localparam int N_GPIO = 16;
   localparam logic [1:0] OP_RD   = 2'd0;
   localparam logic [1:0] OP_WR   = 2'd1;
   localparam logic [1:0] OP_POLL = 2'd2;
   localparam logic [REG_DW-1:0] ALL = 32'hFFFFFFFF;

   // One table row with inputs first and expected outputs after
   // fn_in holds {uart txd, pwm1, pwm0}
   // exp_flags holds {uart rxd, irq, soft irq}
   typedef struct packed {
      logic [1:0]        op;
      logic [3:0]        idle;
      logic [REG_AW-1:0] addr;
      logic [REG_DW-1:0] wdata;
      logic [3:0]        be;
      logic [15:0]       pad;
      logic [6:0]        ext;
      logic [2:0]        fn_in;
      logic [REG_DW-1:0] exp_rd;
      logic [REG_DW-1:0] rd_mask;
      logic              exp_err;
      logic [15:0]       exp_out;
      logic [15:0]       out_mask;
      logic [15:0]       exp_oen;
      logic [2:0]        exp_flags;
   } row_t;

   logic              mclk;
   logic              s_reset_ssn;
   reg_req_t          reg_req;
   reg_rsp_t          reg_rsp;
   logic              reg_err;
   logic [6:0]        ext_irq;
   logic              uart_txd;
   logic              uart_rxd;
   logic [1:0]        pwm_wfm;
   logic [N_GPIO-1:0] pad_in;
   logic [N_GPIO-1:0] pad_out;
   logic [N_GPIO-1:0] pad_oen;
   logic              irq;
   logic              soft_irq;

   row_t        rows[$];
   int          seed        = 68594;
   logic [15:0] rnd_pad;
   int          cycle_cnt   = 0;
   int          cycle_limit = 1000;
   int          err_cnt     = 0;
   int          check_cnt   = 0;
   int          row_err     = 0;
   int          row_idx     = 0;

   pinmux_top #(
      .N_GPIO (N_GPIO)
   ) dut_i (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .reg_req_i   (reg_req),
      .reg_rsp_o   (reg_rsp),
      .reg_err_o   (reg_err),
      .ext_irq_i   (ext_irq),
      .uart_txd_i  (uart_txd),
      .uart_rxd_o  (uart_rxd),
      .pwm_wfm_i   (pwm_wfm),
      .pad_in_i    (pad_in),
      .pad_out_o   (pad_out),
      .pad_oen_o   (pad_oen),
      .irq_o       (irq),
      .soft_irq_o  (soft_irq)
   );

   // Bus protocol checker inside the decoder
   bind reg_decode pinmux_chk chk_i (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .req_i       (req_i),
      .rsp_i       (rsp_o),
      .err_i       (err_o)
   );

   initial begin
      mclk = 1'b0;
      forever #10 mclk = ~mclk;
   end

   // Run limit from the table length
   always @(posedge mclk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout: table not finished after %0d cycles", cycle_cnt);
         $display("Test failed");
         $finish;
      end
   end

   function automatic logic [REG_AW-1:0] glbl_addr(input logic [OFS_W-1:0] ofs);
      return {BLK_GLBL, ofs, 2'b00};
   endfunction

   function automatic logic [REG_AW-1:0] gpio_addr(input logic [OFS_W-1:0] ofs);
      return {BLK_GPIO, ofs, 2'b00};
   endfunction

   task automatic add_row(
      input logic [1:0]        op,
      input int                idle,
      input logic [REG_AW-1:0] addr,
      input logic [REG_DW-1:0] wdata,
      input logic [3:0]        be,
      input logic [15:0]       pad,
      input logic [6:0]        ext,
      input logic [2:0]        fn_in,
      input logic [REG_DW-1:0] exp_rd,
      input logic [REG_DW-1:0] rd_mask,
      input logic              exp_err,
      input logic [15:0]       exp_out,
      input logic [15:0]       out_mask,
      input logic [15:0]       exp_oen,
      input logic [2:0]        exp_flags
   );
      rows.push_back('{op, 4'(idle), addr, wdata, be, pad, ext, fn_in,
                       exp_rd, rd_mask, exp_err, exp_out, out_mask, exp_oen, exp_flags});
   endtask

   // ---------------------------------------------------------------
   // Stimulus table
   // ---------------------------------------------------------------
   task automatic build_table();
      // Reset state
      add_row(OP_RD, 0, gpio_addr(GPIO_DIR), 32'h0, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h0, ALL, 1'b0, 16'h0000, 16'hFFFF, 16'hFFFF, 3'b100);
      add_row(OP_RD, 0, glbl_addr(GLBL_IRQ_MASK), 32'h0, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h0, ALL, 1'b0, 16'h0000, 16'hFFFF, 16'hFFFF, 3'b100);
      add_row(OP_RD, 0, glbl_addr(GLBL_FUNC_SEL), 32'h0, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h0, ALL, 1'b0, 16'h0000, 16'hFFFF, 16'hFFFF, 3'b100);
      // Byte lanes on GPIO_OUT and the mask
      add_row(OP_WR, 0, gpio_addr(GPIO_OUT), 32'h00001234, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h1234, 16'hFFFF, 16'hFFFF, 3'b100);
      add_row(OP_WR, 0, gpio_addr(GPIO_OUT), 32'hFFFF56AB, 4'h1, 16'h0, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFFFF, 3'b100);
      add_row(OP_RD, 0, gpio_addr(GPIO_OUT), 32'h0, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h000012AB, ALL, 1'b0, 16'h12AB, 16'hFFFF, 16'hFFFF, 3'b100);
      add_row(OP_WR, 0, glbl_addr(GLBL_IRQ_MASK), 32'h000000F0, 4'h2, 16'h0, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFFFF, 3'b100);
      add_row(OP_RD, 0, glbl_addr(GLBL_IRQ_MASK), 32'h0, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h0, ALL, 1'b0, 16'h12AB, 16'hFFFF, 16'hFFFF, 3'b100);
      add_row(OP_WR, 0, glbl_addr(GLBL_IRQ_MASK), 32'h0000FF3C, 4'h1, 16'h0, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFFFF, 3'b100);
      add_row(OP_RD, 0, glbl_addr(GLBL_IRQ_MASK), 32'h0, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h0000003C, ALL, 1'b0, 16'h12AB, 16'hFFFF, 16'hFFFF, 3'b100);
      // Random pad value through the synchronizer
      add_row(OP_RD, 3, gpio_addr(GPIO_IN), 32'h0, 4'hF, rnd_pad, 7'h0, 3'b000,
              {16'h0, rnd_pad}, ALL, 1'b0, 16'h12AB, 16'hFFFF, 16'hFFFF, 3'b100);
      // Unmapped block select 5 followed by a normal access
      add_row(OP_RD, 0, {4'd5, 5'd0, 2'b00}, 32'h0, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h0, ALL, 1'b1, 16'h12AB, 16'hFFFF, 16'hFFFF, 3'b100);
      add_row(OP_RD, 0, gpio_addr(GPIO_DIR), 32'h0, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h0, ALL, 1'b0, 16'h12AB, 16'hFFFF, 16'hFFFF, 3'b100);
      // Pad multiplexing with the low byte as outputs
      add_row(OP_WR, 0, gpio_addr(GPIO_DIR), 32'h000000FF, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b100);
      add_row(OP_WR, 0, glbl_addr(GLBL_FUNC_SEL), 32'h7, 4'h1, 16'h0002, 7'h0, 3'b101,
              32'h0, 32'h0, 1'b0, 16'h12A7, 16'hFFFD, 16'hFF02, 3'b100);
      add_row(OP_RD, 0, glbl_addr(GLBL_FUNC_SEL), 32'h0, 4'hF, 16'h0, 7'h0, 3'b010,
              32'h7, ALL, 1'b0, 16'h12A8, 16'hFFFD, 16'hFF02, 3'b000);
      add_row(OP_WR, 0, glbl_addr(GLBL_FUNC_SEL), 32'h0, 4'h1, 16'h0, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b100);
      // GPIO rising edge interrupt on pin 4
      add_row(OP_WR, 0, glbl_addr(GLBL_IRQ_MASK), 32'h01, 4'h1, 16'h0, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b100);
      add_row(OP_WR, 0, gpio_addr(GPIO_RISE_EN), 32'h10, 4'hF, 16'h0, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b100);
      add_row(OP_POLL, 0, glbl_addr(GLBL_IRQ_STAT), 32'h0, 4'hF, 16'h0010, 7'h0, 3'b000,
              32'h1, 32'h1, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b110);
      add_row(OP_RD, 0, gpio_addr(GPIO_INT_STAT), 32'h0, 4'hF, 16'h0010, 7'h0, 3'b000,
              32'h10, ALL, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b110);
      add_row(OP_WR, 0, gpio_addr(GPIO_INT_STAT), 32'h10, 4'h1, 16'h0010, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b110);
      add_row(OP_WR, 0, glbl_addr(GLBL_IRQ_STAT), 32'h01, 4'h1, 16'h0010, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b100);
      // Pin 4 falls and pin 5 rises with neither edge enabled
      add_row(OP_RD, 4, gpio_addr(GPIO_INT_STAT), 32'h0, 4'hF, 16'h0020, 7'h0, 3'b000,
              32'h0, ALL, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b100);
      // Soft and external interrupts
      add_row(OP_WR, 0, glbl_addr(GLBL_SOFT_IRQ), 32'h1, 4'h1, 16'h0020, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b101);
      add_row(OP_RD, 0, glbl_addr(GLBL_SOFT_IRQ), 32'h0, 4'hF, 16'h0020, 7'h0, 3'b000,
              32'h1, ALL, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b101);
      add_row(OP_RD, 2, glbl_addr(GLBL_IRQ_STAT), 32'h0, 4'hF, 16'h0020, 7'h04, 3'b000,
              32'h08, ALL, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b101);
      add_row(OP_WR, 0, glbl_addr(GLBL_IRQ_MASK), 32'h09, 4'h1, 16'h0020, 7'h04, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b111);
      add_row(OP_WR, 0, glbl_addr(GLBL_IRQ_MASK), 32'h01, 4'h1, 16'h0020, 7'h04, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b101);
      add_row(OP_WR, 0, glbl_addr(GLBL_SOFT_IRQ), 32'h0, 4'h1, 16'h0020, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b100);
      add_row(OP_WR, 0, glbl_addr(GLBL_IRQ_STAT), 32'hFF, 4'h1, 16'h0020, 7'h0, 3'b000,
              32'h0, 32'h0, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b100);
      add_row(OP_RD, 0, glbl_addr(GLBL_IRQ_STAT), 32'h0, 4'hF, 16'h0020, 7'h0, 3'b000,
              32'h0, ALL, 1'b0, 16'h12AB, 16'hFFFF, 16'hFF00, 3'b100);
   endtask

   // One bus access from falling edge to falling edge
   task automatic run_access(input row_t r, output logic [REG_DW-1:0] rdata,
                             output logic err);
      reg_req.cs    = 1'b1;
      reg_req.wr    = (r.op == OP_WR);
      reg_req.addr  = r.addr;
      reg_req.wdata = r.wdata;
      reg_req.be    = r.be;
      do begin
         @(negedge mclk);
      end while (reg_rsp.ack !== 1'b1);
      rdata      = reg_rsp.rdata;
      err        = reg_err;
      reg_req.cs = 1'b0;
   endtask

   task automatic compare_val(input string what, input logic [31:0] got,
                              input logic [31:0] exp, input logic [31:0] mask);
      check_cnt++;
      if ((got & mask) !== (exp & mask)) begin
         err_cnt++;
         row_err++;
         $display("Error at time %0t: row %0d %s is %h, expected %h", $time, row_idx,
                  what, got & mask, exp & mask);
      end
   endtask

   // ---------------------------------------------------------------
   // Main sequence
   // ---------------------------------------------------------------
   initial begin
      row_t              r;
      logic [REG_DW-1:0] rdata;
      logic              err;
      int                chk_errs;
      reg_req     = '0;
      ext_irq     = '0;
      uart_txd    = 1'b0;
      pwm_wfm     = '0;
      pad_in      = '0;
      s_reset_ssn = 1'b0;
      rnd_pad     = 16'($random(seed));
      build_table();
      cycle_limit = 10 * rows.size();
      repeat (2) @(posedge mclk);
      @(negedge mclk);
      s_reset_ssn = 1'b1;

      for (int i = 0; i < rows.size(); i++) begin
         r       = rows[i];
         row_idx = i;
         row_err = 0;
         @(negedge mclk);
         pad_in   = r.pad;
         ext_irq  = r.ext;
         uart_txd = r.fn_in[2];
         pwm_wfm  = r.fn_in[1:0];
         repeat (r.idle) @(negedge mclk);
         run_access(r, rdata, err);
         // Poll until the status bits show up
         if (r.op == OP_POLL) begin
            while ((rdata & r.rd_mask) !== (r.exp_rd & r.rd_mask)) begin
               @(negedge mclk);
               run_access(r, rdata, err);
            end
         end
         // Whole status word once the poll has ended
         if (r.op != OP_WR) begin
            compare_val("rdata", rdata, r.exp_rd, (r.op == OP_POLL) ? ALL : r.rd_mask);
         end
         compare_val("reg_err_o", 32'(err), 32'(r.exp_err), 32'h1);
         compare_val("pad_out_o", 32'(pad_out), 32'(r.exp_out), 32'(r.out_mask));
         compare_val("pad_oen_o", 32'(pad_oen), 32'(r.exp_oen), 32'hFFFF);
         compare_val("uart_rxd_o", 32'(uart_rxd), 32'(r.exp_flags[2]), 32'h1);
         compare_val("irq_o", 32'(irq), 32'(r.exp_flags[1]), 32'h1);
         compare_val("soft_irq_o", 32'(soft_irq), 32'(r.exp_flags[0]), 32'h1);
         $display("Row %0d %s at %h: %0d errors", i,
                  (r.op == OP_WR) ? "write" : ((r.op == OP_POLL) ? "poll" : "read"),
                  r.addr, row_err);
      end

      // Failures of the bus protocol checker
      chk_errs = dut_i.u_decode.chk_i.fail_cnt;
      $display("Rows %0d, checks %0d, errors %0d, assertion failures %0d",
               rows.size(), check_cnt, err_cnt, chk_errs);
      if (err_cnt == 0 && chk_errs == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== bench/pinmux_chk.sv ====
// ---------------------------------------------------------------------
// Register bus protocol checker
// Bound to the bus decoder, watches the ack pulse, the error flag
// and the link between chip select and ack
// ---------------------------------------------------------------------
module pinmux_chk import pinmux_pkg::*; (
   input logic     mclk,
   input logic     s_reset_ssn,
   input reg_req_t req_i,
   input reg_rsp_t rsp_i,
   input logic     err_i
);

   // Failed assertions, read by the testbench at the end
   int fail_cnt = 0;

   // Ack is a single-cycle pulse
   ack_pulse: assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      rsp_i.ack |=> !rsp_i.ack)
   else begin
      $error("ack held high for more than one cycle");
      fail_cnt++;
   end

   // Error flag only together with an ack
   err_with_ack: assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      err_i |-> rsp_i.ack)
   else begin
      $error("error flag without ack");
      fail_cnt++;
   end

   // Every ack answers a cycle with cs high
   ack_after_cs: assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      rsp_i.ack |-> $past(req_i.cs))
   else begin
      $error("ack without chip select in the cycle before");
      fail_cnt++;
   end

endmodule

// ==== hdl/pinmux_top.sv ====
// ---------------------------------------------------------------------
// Pin-multiplexing peripheral, top level
// Register decode, global and GPIO register blocks, pad multiplexer
// ---------------------------------------------------------------------
module pinmux_top import pinmux_pkg::*; #(
   parameter int N_GPIO = 16
) (
   input  logic              mclk,
   input  logic              s_reset_ssn,
   input  reg_req_t          reg_req_i,
   output reg_rsp_t          reg_rsp_o,
   output logic              reg_err_o,
   input  logic [6:0]        ext_irq_i,
   input  logic              uart_txd_i,
   output logic              uart_rxd_o,
   input  logic [1:0]        pwm_wfm_i,
   input  logic [N_GPIO-1:0] pad_in_i,
   output logic [N_GPIO-1:0] pad_out_o,
   output logic [N_GPIO-1:0] pad_oen_o,
   output logic              irq_o,
   output logic              soft_irq_o
);

   reg_req_t          glbl_req;
   reg_req_t          gpio_req;
   reg_rsp_t          glbl_rsp;
   reg_rsp_t          gpio_rsp;
   logic              gpio_intr;
   logic [N_FUNC-1:0] func_sel;
   logic [N_GPIO-1:0] gpio_out;
   logic [N_GPIO-1:0] gpio_dir;
   logic [N_GPIO-1:0] pad_gpio_in;

   // ---------------------------------------------------------------
   // Bus decode
   // ---------------------------------------------------------------
   reg_decode u_decode (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .req_i       (reg_req_i),
      .glbl_req_o  (glbl_req),
      .gpio_req_o  (gpio_req),
      .glbl_rsp_i  (glbl_rsp),
      .gpio_rsp_i  (gpio_rsp),
      .rsp_o       (reg_rsp_o),
      .err_o       (reg_err_o)
   );

   // Global block, interrupt collection
   glbl_reg u_glbl (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .req_i       (glbl_req),
      .rsp_o       (glbl_rsp),
      .gpio_intr_i (gpio_intr),
      .ext_irq_i   (ext_irq_i),
      .func_sel_o  (func_sel),
      .irq_o       (irq_o),
      .soft_irq_o  (soft_irq_o)
   );

   gpio_regs #(
      .N_GPIO (N_GPIO)
   ) u_gpio (
      .mclk          (mclk),
      .s_reset_ssn   (s_reset_ssn),
      .req_i         (gpio_req),
      .rsp_o         (gpio_rsp),
      .pad_gpio_in_i (pad_gpio_in),
      .gpio_out_o    (gpio_out),
      .gpio_dir_o    (gpio_dir),
      .gpio_intr_o   (gpio_intr)
   );

   // Pads
   pad_mux #(
      .N_GPIO (N_GPIO)
   ) u_pad_mux (
      .func_sel_i    (func_sel),
      .gpio_out_i    (gpio_out),
      .gpio_dir_i    (gpio_dir),
      .uart_txd_i    (uart_txd_i),
      .pwm_wfm_i     (pwm_wfm_i),
      .pad_in_i      (pad_in_i),
      .pad_out_o     (pad_out_o),
      .pad_oen_o     (pad_oen_o),
      .pad_gpio_in_o (pad_gpio_in),
      .uart_rxd_o    (uart_rxd_o)
   );

endmodule

// ==== pinmux/pad_mux.sv ====
// ---------------------------------------------------------------------
// Pad multiplexer
// Each pad carries its GPIO unless a fixed peripheral function owns
// it; covers output value, output enable and the input side
// ---------------------------------------------------------------------
module pad_mux import pinmux_pkg::*; #(
   parameter int N_GPIO = 16
) (
   input  logic [N_FUNC-1:0] func_sel_i,
   input  logic [N_GPIO-1:0] gpio_out_i,
   input  logic [N_GPIO-1:0] gpio_dir_i,
   input  logic              uart_txd_i,
   input  logic [1:0]        pwm_wfm_i,
   input  logic [N_GPIO-1:0] pad_in_i,
   output logic [N_GPIO-1:0] pad_out_o,
   output logic [N_GPIO-1:0] pad_oen_o,
   output logic [N_GPIO-1:0] pad_gpio_in_o,
   output logic              uart_rxd_o
);

   always_comb begin
      // GPIO default, oen is active low so dir 1 drives the pad
      pad_out_o  = gpio_out_i;
      pad_oen_o  = ~gpio_dir_i;
      // Idle UART line level
      uart_rxd_o = 1'b1;

      // UART owns TX and RX pads
      if (func_sel_i[FUNC_UART]) begin
         pad_out_o[PIN_UART_TX] = uart_txd_i;
         pad_oen_o[PIN_UART_TX] = 1'b0;
         // RX pad forced to input
         pad_oen_o[PIN_UART_RX] = 1'b1;
         uart_rxd_o             = pad_in_i[PIN_UART_RX];
      end

      // PWM waveforms, output only
      if (func_sel_i[FUNC_PWM0]) begin
         pad_out_o[PIN_PWM0] = pwm_wfm_i[0];
         pad_oen_o[PIN_PWM0] = 1'b0;
      end
      if (func_sel_i[FUNC_PWM1]) begin
         pad_out_o[PIN_PWM1] = pwm_wfm_i[1];
         pad_oen_o[PIN_PWM1] = 1'b0;
      end
   end

   // GPIO always sees the raw pad, even on function pads
   assign pad_gpio_in_o = pad_in_i;

endmodule

// ==== gpio/gpio_regs.sv ====
// ---------------------------------------------------------------------
// GPIO register block
// Direction, output value, synchronized input, per-pin edge enables
// and the edge interrupt status
// ---------------------------------------------------------------------
module gpio_regs import pinmux_pkg::*; #(
   parameter int N_GPIO = 16
) (
   input  logic              mclk,
   input  logic              s_reset_ssn,
   input  reg_req_t          req_i,
   output reg_rsp_t          rsp_o,
   input  logic [N_GPIO-1:0] pad_gpio_in_i,
   output logic [N_GPIO-1:0] gpio_out_o,
   output logic [N_GPIO-1:0] gpio_dir_o,
   output logic              gpio_intr_o
);

   logic [OFS_W-1:0]  ofs;
   logic              sample;
   logic              wr_en;
   logic              ack_q;
   logic [REG_DW-1:0] rdata_q;
   logic [REG_DW-1:0] rd_word;
   logic [REG_DW-1:0] wr_merge;
   logic [REG_DW-1:0] wr_lanes;
   logic [N_GPIO-1:0] dir_q;
   logic [N_GPIO-1:0] out_q;
   logic [N_GPIO-1:0] rise_en_q;
   logic [N_GPIO-1:0] fall_en_q;
   logic [N_GPIO-1:0] int_stat_q;
   logic [N_GPIO-1:0] int_set;
   logic [N_GPIO-1:0] int_clr;
   logic [N_GPIO-1:0] pin_sync;
   logic [N_GPIO-1:0] pin_rise;
   logic [N_GPIO-1:0] pin_fall;

   // Pad input synchronizer and edge pulses
   gpio_edge #(
      .N_GPIO (N_GPIO)
   ) u_edge (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .async_i     (pad_gpio_in_i),
      .sync_o      (pin_sync),
      .rise_o      (pin_rise),
      .fall_o      (pin_fall)
   );

   assign ofs    = req_i.addr[OFS_MSB:OFS_LSB];
   assign sample = req_i.cs & ~ack_q;
   assign wr_en  = sample & req_i.wr;

   // ---------------------------------------------------------------
   // Read mux
   // ---------------------------------------------------------------
   always_comb begin
      case (ofs)
         GPIO_DIR:      rd_word = REG_DW'(dir_q);
         GPIO_OUT:      rd_word = REG_DW'(out_q);
         GPIO_IN:       rd_word = REG_DW'(pin_sync);
         GPIO_RISE_EN:  rd_word = REG_DW'(rise_en_q);
         GPIO_FALL_EN:  rd_word = REG_DW'(fall_en_q);
         GPIO_INT_STAT: rd_word = REG_DW'(int_stat_q);
         default:       rd_word = '0;
      endcase
   end

   assign wr_merge = be_merge(rd_word, req_i.wdata, req_i.be);
   assign wr_lanes = be_merge('0, req_i.wdata, req_i.be);

   // Enabled edges set status, write 1 clears
   assign int_set = (pin_rise & rise_en_q) | (pin_fall & fall_en_q);
   assign int_clr = (wr_en && ofs == GPIO_INT_STAT) ? wr_lanes[N_GPIO-1:0] : '0;

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         ack_q      <= 1'b0;
         dir_q      <= '0;
         out_q      <= '0;
         rise_en_q  <= '0;
         fall_en_q  <= '0;
         int_stat_q <= '0;
      end else begin
         ack_q      <= sample;
         int_stat_q <= (int_stat_q & ~int_clr) | int_set;
         // GPIO_IN is read only, so it has no write case
         if (wr_en) begin
            case (ofs)
               GPIO_DIR:     dir_q     <= wr_merge[N_GPIO-1:0];
               GPIO_OUT:     out_q     <= wr_merge[N_GPIO-1:0];
               GPIO_RISE_EN: rise_en_q <= wr_merge[N_GPIO-1:0];
               GPIO_FALL_EN: fall_en_q <= wr_merge[N_GPIO-1:0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge mclk) begin
      if (sample) begin
         rdata_q <= rd_word;
      end
   end

   assign rsp_o       = '{rdata: rdata_q, ack: ack_q};
   assign gpio_out_o  = out_q;
   assign gpio_dir_o  = dir_q;
   assign gpio_intr_o = |int_stat_q;

endmodule

// ==== gpio/gpio_edge.sv ====
// ---------------------------------------------------------------------
// GPIO input synchronizer
// Two flops per pin into the clock domain, a third for edge detect,
// one-cycle rise and fall pulses
// ---------------------------------------------------------------------
module gpio_edge #(
   parameter int N_GPIO = 16
) (
   input  logic              mclk,
   input  logic              s_reset_ssn,
   input  logic [N_GPIO-1:0] async_i,
   output logic [N_GPIO-1:0] sync_o,
   output logic [N_GPIO-1:0] rise_o,
   output logic [N_GPIO-1:0] fall_o
);

   logic [N_GPIO-1:0] meta_q;
   logic [N_GPIO-1:0] sync_q;
   logic [N_GPIO-1:0] dly_q;

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         meta_q <= '0;
         sync_q <= '0;
         dly_q  <= '0;
      end else begin
         // First stage may go metastable
         meta_q <= async_i;
         sync_q <= meta_q;
         // Previous synchronized value
         dly_q  <= sync_q;
      end
   end

   assign sync_o = sync_q;
   assign rise_o = sync_q & ~dly_q;
   assign fall_o = ~sync_q & dly_q;

endmodule

// ==== glbl/glbl_reg.sv ====
// ---------------------------------------------------------------------
// Global register block
// Soft interrupt, interrupt status with mask, and the peripheral
// function select bits
// ---------------------------------------------------------------------
module glbl_reg import pinmux_pkg::*; (
   input  logic              mclk,
   input  logic              s_reset_ssn,
   input  reg_req_t          req_i,
   output reg_rsp_t          rsp_o,
   input  logic              gpio_intr_i,
   input  logic [6:0]        ext_irq_i,
   output logic [N_FUNC-1:0] func_sel_o,
   output logic              irq_o,
   output logic              soft_irq_o
);

   logic [OFS_W-1:0]  ofs;
   logic              sample;
   logic              wr_en;
   logic              ack_q;
   logic [REG_DW-1:0] rdata_q;
   logic [REG_DW-1:0] rd_word;
   logic [REG_DW-1:0] wr_merge;
   logic [REG_DW-1:0] wr_lanes;
   logic              soft_q;
   logic [N_IRQ-1:0]  mask_q;
   logic [N_IRQ-1:0]  stat_q;
   logic [N_IRQ-1:0]  irq_src;
   logic [N_IRQ-1:0]  stat_clr;
   logic [N_FUNC-1:0] func_q;

   assign ofs    = req_i.addr[OFS_MSB:OFS_LSB];
   // Access taken only while our ack is low
   assign sample = req_i.cs & ~ack_q;
   assign wr_en  = sample & req_i.wr;

   // ---------------------------------------------------------------
   // Read mux, unused offsets read as zero
   // ---------------------------------------------------------------
   always_comb begin
      case (ofs)
         GLBL_SOFT_IRQ: rd_word = REG_DW'(soft_q);
         GLBL_IRQ_MASK: rd_word = REG_DW'(mask_q);
         GLBL_IRQ_STAT: rd_word = REG_DW'(stat_q);
         GLBL_FUNC_SEL: rd_word = REG_DW'(func_q);
         default:       rd_word = '0;
      endcase
   end

   // Write data merged with current value per byte lane
   assign wr_merge = be_merge(rd_word, req_i.wdata, req_i.be);
   // Write-1-to-clear bits, disabled lanes clear nothing
   assign wr_lanes = be_merge('0, req_i.wdata, req_i.be);

   // Status sources, GPIO at bit 0 then the external lines
   assign irq_src  = {ext_irq_i, gpio_intr_i};
   assign stat_clr = (wr_en && ofs == GLBL_IRQ_STAT) ? wr_lanes[N_IRQ-1:0] : '0;

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         ack_q  <= 1'b0;
         soft_q <= 1'b0;
         mask_q <= '0;
         stat_q <= '0;
         func_q <= '0;
      end else begin
         ack_q  <= sample;
         // Set wins over a clear in the same cycle
         stat_q <= (stat_q & ~stat_clr) | irq_src;
         if (wr_en) begin
            case (ofs)
               GLBL_SOFT_IRQ: soft_q <= wr_merge[0];
               GLBL_IRQ_MASK: mask_q <= wr_merge[N_IRQ-1:0];
               GLBL_FUNC_SEL: func_q <= wr_merge[N_FUNC-1:0];
               default: ;
            endcase
         end
      end
   end

   // Read data captured at the sampling edge
   always_ff @(posedge mclk) begin
      if (sample) begin
         rdata_q <= rd_word;
      end
   end

   assign rsp_o      = '{rdata: rdata_q, ack: ack_q};
   assign irq_o      = |(stat_q & mask_q);
   assign soft_irq_o = soft_q;
   assign func_sel_o = func_q;

endmodule

// ==== hdl/reg_decode.sv ====
// ---------------------------------------------------------------------
// Register bus decoder
// Routes chip select to the addressed block, returns the matching
// response and acks unmapped block selects with an error
// ---------------------------------------------------------------------
module reg_decode import pinmux_pkg::*; (
   input  logic     mclk,
   input  logic     s_reset_ssn,
   input  reg_req_t req_i,
   output reg_req_t glbl_req_o,
   output reg_req_t gpio_req_o,
   input  reg_rsp_t glbl_rsp_i,
   input  reg_rsp_t gpio_rsp_i,
   output reg_rsp_t rsp_o,
   output logic     err_o
);

   logic [BLK_W-1:0] blk_req;
   logic [BLK_W-1:0] blk_q;
   logic             unmap_req;
   logic             err_ack_q;

   // Block select straight from the live address
   assign blk_req   = req_i.addr[BLK_MSB:BLK_LSB];
   assign unmap_req = (blk_req != BLK_GLBL) && (blk_req != BLK_GPIO);

   // Same request to both blocks, cs only to the addressed one
   always_comb begin
      glbl_req_o    = req_i;
      gpio_req_o    = req_i;
      glbl_req_o.cs = req_i.cs & (blk_req == BLK_GLBL);
      gpio_req_o.cs = req_i.cs & (blk_req == BLK_GPIO);
   end

   // Stored select lines up with the block ack one cycle later
   // Own one-cycle ack for a block nobody answers
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         blk_q     <= BLK_GLBL;
         err_ack_q <= 1'b0;
      end else begin
         if (req_i.cs) begin
            blk_q <= blk_req;
         end
         err_ack_q <= req_i.cs & unmap_req & ~err_ack_q;
      end
   end

   // Response mux
   always_comb begin
      case (blk_q)
         BLK_GLBL: rsp_o = glbl_rsp_i;
         BLK_GPIO: rsp_o = gpio_rsp_i;
         default:  rsp_o = '{rdata: '0, ack: err_ack_q};
      endcase
   end

   // Only set while an unmapped select is stored
   assign err_o = err_ack_q;

endmodule

// ==== common/pinmux_pkg.sv ====
// ---------------------------------------------------------------------
// Pin-multiplexing peripheral, shared definitions
// Register bus types, address map, register offsets, interrupt
// layout and the fixed pad map of the peripheral functions
// ---------------------------------------------------------------------
package pinmux_pkg;

   // Register bus geometry
   localparam int REG_AW  = 11;
   localparam int REG_DW  = 32;

   // Block select field of the address
   localparam int BLK_MSB = 10;
   localparam int BLK_LSB = 7;
   localparam int BLK_W   = BLK_MSB - BLK_LSB + 1;
   localparam logic [BLK_W-1:0] BLK_GLBL = 4'd0;
   localparam logic [BLK_W-1:0] BLK_GPIO = 4'd1;

   // Word offset field inside a block
   localparam int OFS_MSB = 6;
   localparam int OFS_LSB = 2;
   localparam int OFS_W   = OFS_MSB - OFS_LSB + 1;

   // Global block register offsets
   localparam logic [OFS_W-1:0] GLBL_SOFT_IRQ = 5'd0;
   localparam logic [OFS_W-1:0] GLBL_IRQ_MASK = 5'd1;
   localparam logic [OFS_W-1:0] GLBL_IRQ_STAT = 5'd2;
   localparam logic [OFS_W-1:0] GLBL_FUNC_SEL = 5'd3;

   // GPIO block register offsets
   localparam logic [OFS_W-1:0] GPIO_DIR      = 5'd0;
   localparam logic [OFS_W-1:0] GPIO_OUT      = 5'd1;
   localparam logic [OFS_W-1:0] GPIO_IN       = 5'd2;
   localparam logic [OFS_W-1:0] GPIO_RISE_EN  = 5'd3;
   localparam logic [OFS_W-1:0] GPIO_FALL_EN  = 5'd4;
   localparam logic [OFS_W-1:0] GPIO_INT_STAT = 5'd5;

   // Interrupt status layout, bit 0 from GPIO, the rest external
   localparam int N_IRQ        = 8;
   localparam int IRQ_GPIO_BIT = 0;

   // Function select bits
   localparam int FUNC_UART = 0;
   localparam int FUNC_PWM0 = 1;
   localparam int FUNC_PWM1 = 2;
   localparam int N_FUNC    = 3;

   // Fixed pads of the peripheral functions
   localparam int PIN_UART_TX = 0;
   localparam int PIN_UART_RX = 1;
   localparam int PIN_PWM0    = 2;
   localparam int PIN_PWM1    = 3;

   // Request from the bus master, forwarded per block
   typedef struct packed {
      logic              cs;
      logic              wr;
      logic [REG_AW-1:0] addr;
      logic [REG_DW-1:0] wdata;
      logic [3:0]        be;
   } reg_req_t;

   // Block response, rdata valid while ack is high
   typedef struct packed {
      logic [REG_DW-1:0] rdata;
      logic              ack;
   } reg_rsp_t;

   // Byte-lane merge of write data into an old register word
   function automatic logic [REG_DW-1:0] be_merge(input logic [REG_DW-1:0] old_val,
                                                 input logic [REG_DW-1:0] new_val,
                                                 input logic [3:0]        be);
      logic [REG_DW-1:0] res;
      res = old_val;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

endpackage
